/* filelist.f */
hw/ddr_rw_pkg.sv
hw/strobe_sync.sv
hw/p0_write_sequencer.sv
hw/p1_read_sequencer.sv
hw/ddr_rw.sv
verification/ddr_rw_checker.sv
verification/ddr_rw_tb.sv

/* verification/ddr_rw_tb.sv */
`default_nettype none

module ddr_rw_tb import ddr_rw_pkg::*; ();

   localparam int drive_delay   = 10;   // after the rising edge
   localparam int settle_cycles = 4;    // strobe sync plus address load
   localparam int wait_margin   = 20;

   typedef enum {op_wr_slot, op_rd_slot, op_write, op_read, op_rden, op_calib} op_t;

   typedef struct {
      op_t        op;
      beat_t      operand;    // slot in the low bits, or data
      int         hold;       // full-flag cycles, or calib_done low time
      byte_addr_t exp_addr;
      beat_t      exp_data;
   } step_t;

   logic        c3_clk0, rst, calib_done;
   logic        wren, rden, rd_cmd, addr_wr_set, addr_rd_set;
   frame_slot_t frame_switch;
   beat_t       camera_data, p1_rd_data;
   logic        p0_wr_full, p0_cmd_full, p1_cmd_full;
   logic        p0_wr_en, p0_cmd_en, p1_cmd_en, p1_rd_en;
   beat_t       p0_wr_data, rd_data;
   byte_addr_t  p0_cmd_byte_addr, p1_cmd_byte_addr;
   cmd_instr_t  p0_cmd_instr, p1_cmd_instr;
   burst_len_t  p0_cmd_bl, p1_cmd_bl;

   step_t       steps[$];
   int          errors;
   byte_addr_t  wr_next;   // expected next write address
   byte_addr_t  rd_next;   // expected next read address

   ddr_rw DUT (.*);

   always #50 c3_clk0 = ~c3_clk0;

   ////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////

   task automatic report_failure();
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic check_addr(input string name, input byte_addr_t got, input byte_addr_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
         report_failure();
      end
   endtask

   task automatic check_beat(input string name, input beat_t got, input beat_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
         report_failure();
      end
   endtask

   task automatic check_instr(input string name, input cmd_instr_t got, input cmd_instr_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
         report_failure();
      end
   endtask

   task automatic check_bl(input string name, input burst_len_t got, input burst_len_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
         report_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
         errors++;
         report_failure();
      end
   endtask

   task automatic check_quiet();
      check_flag("p0_wr_en", p0_wr_en, 1'b0);
      check_flag("p0_cmd_en", p0_cmd_en, 1'b0);
      check_flag("p1_cmd_en", p1_cmd_en, 1'b0);
      check_flag("p1_rd_en", p1_rd_en, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////
   // full-flag model and enable waits
   ////////////////////////////////////////////////////////////

   task automatic after_edge();
      @(posedge c3_clk0);
      #drive_delay;
   endtask

   // 0 data write, 1 write command, 2 read command, 3 read strobe
   task automatic set_full(input int which, input logic level);
      case (which)
         0: p0_wr_full = level;
         1: p0_cmd_full = level;
         2: p1_cmd_full = level;
         default: ;
      endcase
   endtask

   function automatic logic enable_of(input int which);
      case (which)
         0: return p0_wr_en;
         1: return p0_cmd_en;
         2: return p1_cmd_en;
         default: return p1_rd_en;
      endcase
   endfunction

   task automatic wait_enable(input int which, input int hold, input string what);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen) begin
         after_edge();
         set_full(which, cycles < hold);   // flag held for the first hold cycles
         @(negedge c3_clk0);
         seen = enable_of(which);
         cycles++;
         if (!seen && cycles > hold + wait_margin) begin
            $display("timed out waiting for %s after %0d cycles", what, cycles);
            errors++;
            report_failure();
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////////////////////////

   function automatic beat_t rand_beat();
      return {$urandom, $urandom};
   endfunction

   task automatic add_step(input op_t op, input beat_t operand, input int hold);
      step_t s;
      int    slot;
      s.op       = op;
      s.operand  = operand;
      s.hold     = hold;
      s.exp_data = operand;
      s.exp_addr = '0;
      case (op)
         op_wr_slot: begin
            wr_next    = byte_addr_t'(operand[1:0]) * FRAME_STRIDE;
            s.exp_addr = wr_next;
         end
         op_rd_slot: begin
            slot       = (int'(operand[1:0]) + int'(READ_SLOT_OFFSET)) % 4;
            rd_next    = byte_addr_t'(slot) * FRAME_STRIDE;
            s.exp_addr = rd_next;
         end
         op_write: begin
            s.exp_addr = wr_next;
            wr_next    = wr_next + 30'd8;     // one 8-byte beat
         end
         op_read: begin
            s.exp_addr = rd_next;
            rd_next    = rd_next + 30'd320;   // 40 beats of 8 bytes
         end
         op_calib: begin   // both ports fall back to their reset addresses
            wr_next = '0;
            rd_next = FRAME_STRIDE;
         end
         default: ;
      endcase
      steps.push_back(s);
   endtask

   task automatic build_table();
      wr_next = '0;
      rd_next = FRAME_STRIDE;
      add_step(op_write, rand_beat(), 0);
      add_step(op_read, '0, 0);
      add_step(op_calib, '0, 3);
      add_step(op_write, rand_beat(), 0);
      add_step(op_read, '0, 0);
      add_step(op_wr_slot, 64'd2, 0);
      repeat (4) add_step(op_write, rand_beat(), 0);
      add_step(op_rd_slot, 64'd3, 0);
      repeat (3) add_step(op_read, '0, 0);
      repeat (4) add_step(op_rden, rand_beat(), 0);   // rising and falling
      add_step(op_wr_slot, 64'd1, 0);
      repeat (6) add_step(op_write, rand_beat(), $urandom_range(0, 6));
      add_step(op_rd_slot, 64'd0, 0);
      repeat (5) add_step(op_read, '0, $urandom_range(0, 6));
      add_step(op_wr_slot, 64'd3, 0);
      repeat (2) add_step(op_write, rand_beat(), $urandom_range(0, 3));
   endtask

   task automatic apply_step(input step_t s);
      case (s.op)
         op_wr_slot, op_rd_slot: begin
            after_edge();
            frame_switch = s.operand[1:0];
            if (s.op == op_wr_slot) addr_wr_set = ~addr_wr_set;
            else addr_rd_set = ~addr_rd_set;
            repeat (settle_cycles) @(posedge c3_clk0);
            @(negedge c3_clk0);
            if (s.op == op_wr_slot) check_addr("p0_cmd_byte_addr", p0_cmd_byte_addr, s.exp_addr);
            else check_addr("p1_cmd_byte_addr", p1_cmd_byte_addr, s.exp_addr);
         end
         op_write: begin
            after_edge();
            camera_data = s.operand;
            wren        = 1'b1;
            after_edge();
            wren = 1'b0;
            wait_enable(0, s.hold, "p0_wr_en");
            camera_data = '0;                   // beat must already be latched
            check_beat("p0_wr_data", p0_wr_data, s.exp_data);
            wait_enable(1, s.hold, "p0_cmd_en");
            check_addr("p0_cmd_byte_addr", p0_cmd_byte_addr, s.exp_addr);
            check_instr("p0_cmd_instr", p0_cmd_instr, CMD_WRITE);
            check_bl("p0_cmd_bl", p0_cmd_bl, '0);
         end
         op_read: begin
            after_edge();
            rd_cmd = 1'b1;
            after_edge();
            rd_cmd = 1'b0;
            wait_enable(2, s.hold, "p1_cmd_en");
            check_addr("p1_cmd_byte_addr", p1_cmd_byte_addr, s.exp_addr);
            check_instr("p1_cmd_instr", p1_cmd_instr, CMD_READ);
            check_bl("p1_cmd_bl", p1_cmd_bl, 6'd39);
         end
         op_rden: begin
            after_edge();
            rden       = ~rden;
            p1_rd_data = s.operand;
            wait_enable(3, 0, "p1_rd_en");
            check_beat("rd_data", rd_data, s.exp_data);
            repeat (3) begin   // exactly one strobe per toggle
               @(negedge c3_clk0);
               check_flag("p1_rd_en", p1_rd_en, 1'b0);
            end
         end
         default: begin        // calib_done drop
            after_edge();
            calib_done  = 1'b0;
            wren        = 1'b1;   // edges that must not get through
            rden        = 1'b1;
            rd_cmd      = 1'b1;
            addr_wr_set = 1'b1;
            addr_rd_set = 1'b1;
            repeat (s.hold + 2) begin
               @(negedge c3_clk0);
               check_quiet();
            end
            after_edge();
            wren        = 1'b0;
            rden        = 1'b0;
            rd_cmd      = 1'b0;
            addr_wr_set = 1'b0;
            addr_rd_set = 1'b0;
            calib_done  = 1'b1;
            @(negedge c3_clk0);
            check_addr("p0_cmd_byte_addr", p0_cmd_byte_addr, s.exp_addr);
            check_addr("p1_cmd_byte_addr", p1_cmd_byte_addr, FRAME_STRIDE);
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(83));
      errors       = 0;
      c3_clk0      = 1'b0;
      rst          = 1'b1;
      calib_done   = 1'b0;
      wren         = 1'b0;
      rden         = 1'b0;
      rd_cmd       = 1'b0;
      addr_wr_set  = 1'b0;
      addr_rd_set  = 1'b0;
      frame_switch = '0;
      camera_data  = '0;
      p1_rd_data   = '0;
      p0_wr_full   = 1'b0;
      p0_cmd_full  = 1'b0;
      p1_cmd_full  = 1'b0;
      build_table();
      repeat (2) @(posedge c3_clk0);
      #drive_delay;
      rst        = 1'b0;
      calib_done = 1'b1;
      repeat (3) begin
         @(negedge c3_clk0);
         check_quiet();
      end
      foreach (steps[i]) apply_step(steps[i]);
      repeat (settle_cycles) @(posedge c3_clk0);
      if (errors == 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         report_failure();
      end
   end

endmodule

`default_nettype wire

/* verification/ddr_rw_checker.sv */
`default_nettype none

module ddr_rw_checker (
   input wire logic c3_clk0,
   input wire logic rst,
   input wire logic calib_done,
   input wire logic p0_wr_full,
   input wire logic p0_cmd_full,
   input wire logic p0_wr_en,
   input wire logic p0_cmd_en,
   input wire logic p1_cmd_en,
   input wire logic p1_rd_en
);

   logic hold;   // reset or memory not calibrated

   assign hold = rst || !calib_done;

   ////////////////////////////////////////////////////////////
   // enables are single-cycle strobes
   ////////////////////////////////////////////////////////////

   wr_en_one_cycle: assert property (@(posedge c3_clk0) p0_wr_en |=> !p0_wr_en)
      else $error("p0_wr_en high for more than one cycle");
   cmd_en_one_cycle: assert property (@(posedge c3_clk0) p0_cmd_en |=> !p0_cmd_en)
      else $error("p0_cmd_en high for more than one cycle");
   rd_cmd_en_one_cycle: assert property (@(posedge c3_clk0) p1_cmd_en |=> !p1_cmd_en)
      else $error("p1_cmd_en high for more than one cycle");
   rd_en_one_cycle: assert property (@(posedge c3_clk0) p1_rd_en |=> !p1_rd_en)
      else $error("p1_rd_en high for more than one cycle");

   // port 0 only writes into FIFOs with room
   wr_en_has_room: assert property (@(posedge c3_clk0) $rose(p0_wr_en) |-> !$past(p0_wr_full))
      else $error("p0_wr_en rose while the data FIFO was full");
   cmd_en_has_room: assert property (@(posedge c3_clk0) $rose(p0_cmd_en) |-> !$past(p0_cmd_full))
      else $error("p0_cmd_en rose while the command FIFO was full");

   quiet_in_hold: assert property (@(posedge c3_clk0)
      hold |=> !(p0_wr_en || p0_cmd_en || p1_cmd_en || p1_rd_en))
      else $error("enable active while held in reset");

endmodule

bind ddr_rw ddr_rw_checker u_ddr_rw_checker (.*);

`default_nettype wire

/* hw/ddr_rw.sv */
`default_nettype none

module ddr_rw import ddr_rw_pkg::*; #(
   parameter byte_addr_t frame_stride     = FRAME_STRIDE,
   parameter int         read_burst_beats = READ_BURST_BEATS
) (
   input  wire logic        c3_clk0,
   input  wire logic        rst,
   input  wire logic        calib_done,
   input  wire logic        wren,
   input  wire logic        rden,
   input  wire logic        rd_cmd,
   input  wire logic        addr_wr_set,
   input  wire logic        addr_rd_set,
   input  wire frame_slot_t frame_switch,
   input  wire beat_t       camera_data,
   input  wire beat_t       p1_rd_data,
   input  wire logic        p0_wr_full,
   input  wire logic        p0_cmd_full,
   input  wire logic        p1_cmd_full,
   output logic             p0_wr_en,
   output logic             p0_cmd_en,
   output beat_t            p0_wr_data,
   output byte_addr_t       p0_cmd_byte_addr,
   output cmd_instr_t       p0_cmd_instr,
   output burst_len_t       p0_cmd_bl,
   output logic             p1_cmd_en,
   output logic             p1_rd_en,
   output byte_addr_t       p1_cmd_byte_addr,
   output cmd_instr_t       p1_cmd_instr,
   output burst_len_t       p1_cmd_bl,
   output beat_t            rd_data
);

   logic wr_req;
   logic rd_cmd_req;
   logic wr_addr_load;
   logic rd_addr_load;

   // fixed command fields
   assign p0_cmd_instr = CMD_WRITE;
   assign p0_cmd_bl    = '0;                                 // single beat
   assign p1_cmd_instr = CMD_READ;
   assign p1_cmd_bl    = burst_len_t'(read_burst_beats - 1);
   assign rd_data      = p1_rd_data;                         // straight to the display

   ////////////////////////////////////////////////////////////
   // sync stage and the two port sequencers
   ////////////////////////////////////////////////////////////

   strobe_sync u_strobe_sync (
      .c3_clk0      (c3_clk0),
      .rst          (rst),
      .calib_done   (calib_done),
      .wren         (wren),
      .rden         (rden),
      .rd_cmd       (rd_cmd),
      .addr_wr_set  (addr_wr_set),
      .addr_rd_set  (addr_rd_set),
      .wr_req       (wr_req),
      .rd_req       (p1_rd_en),       // one read strobe per rden toggle
      .rd_cmd_req   (rd_cmd_req),
      .wr_addr_load (wr_addr_load),
      .rd_addr_load (rd_addr_load)
   );

   p0_write_sequencer #(
      .frame_stride (frame_stride)
   ) u_p0_write_sequencer (
      .c3_clk0          (c3_clk0),
      .rst              (rst),
      .calib_done       (calib_done),
      .wr_req           (wr_req),
      .wr_addr_load     (wr_addr_load),
      .frame_switch     (frame_switch),
      .camera_data      (camera_data),
      .p0_wr_full       (p0_wr_full),
      .p0_cmd_full      (p0_cmd_full),
      .p0_wr_en         (p0_wr_en),
      .p0_cmd_en        (p0_cmd_en),
      .p0_wr_data       (p0_wr_data),
      .p0_cmd_byte_addr (p0_cmd_byte_addr)
   );

   p1_read_sequencer #(
      .frame_stride     (frame_stride),
      .read_burst_beats (read_burst_beats)
   ) u_p1_read_sequencer (
      .c3_clk0          (c3_clk0),
      .rst              (rst),
      .calib_done       (calib_done),
      .rd_cmd_req       (rd_cmd_req),
      .rd_addr_load     (rd_addr_load),
      .frame_switch     (frame_switch),
      .p1_cmd_full      (p1_cmd_full),
      .p1_cmd_en        (p1_cmd_en),
      .p1_cmd_byte_addr (p1_cmd_byte_addr)
   );

endmodule

`default_nettype wire

/* hw/p1_read_sequencer.sv */
`default_nettype none

module p1_read_sequencer import ddr_rw_pkg::*; #(
   parameter byte_addr_t frame_stride     = FRAME_STRIDE,
   parameter int         read_burst_beats = READ_BURST_BEATS
) (
   input  wire logic        c3_clk0,
   input  wire logic        rst,
   input  wire logic        calib_done,
   input  wire logic        rd_cmd_req,     // one-cycle, from strobe_sync
   input  wire logic        rd_addr_load,   // one-cycle, new read frame
   input  wire frame_slot_t frame_switch,
   input  wire logic        p1_cmd_full,
   output logic             p1_cmd_en,
   output byte_addr_t       p1_cmd_byte_addr
);

   // bytes covered by one burst, 40 beats of 8 bytes
   localparam byte_addr_t burst_step = byte_addr_t'(read_burst_beats) * BEAT_BYTES;

   read_state_t state;
   frame_slot_t rd_slot;   // wraps modulo four
   logic        hold;

   assign hold    = rst || !calib_done;
   assign rd_slot = frame_switch + READ_SLOT_OFFSET;

   ////////////////////////////////////////////////////////////
   // burst read command sequence
   ////////////////////////////////////////////////////////////

   always_ff @(posedge c3_clk0) begin
      if (hold) begin
         state            <= read_idle;
         p1_cmd_en        <= 1'b0;
         p1_cmd_byte_addr <= frame_stride;   // slot 1 until the first frame select
      end else if (rd_addr_load) begin
         p1_cmd_en        <= 1'b0;
         p1_cmd_byte_addr <= byte_addr_t'(rd_slot) * frame_stride;
      end else begin
         case (state)
            read_idle: begin
               if (rd_cmd_req) begin
                  state <= read_cmd_start;
               end
            end
            read_cmd_start: begin
               if (!p1_cmd_full) begin  // wait for command FIFO space
                  state <= read_cmd;
               end
            end
            read_cmd: begin
               p1_cmd_en <= 1'b1;
               state     <= read_done;
            end
            read_done: begin
               p1_cmd_en        <= 1'b0;
               p1_cmd_byte_addr <= p1_cmd_byte_addr + burst_step;
               state            <= read_idle;
            end
            default: begin
               p1_cmd_en <= 1'b0;
               state     <= read_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/p0_write_sequencer.sv */
`default_nettype none

module p0_write_sequencer import ddr_rw_pkg::*; #(
   parameter byte_addr_t frame_stride = FRAME_STRIDE
) (
   input  wire logic        c3_clk0,
   input  wire logic        rst,
   input  wire logic        calib_done,
   input  wire logic        wr_req,        // one-cycle, from strobe_sync
   input  wire logic        wr_addr_load,  // one-cycle, new write frame
   input  wire frame_slot_t frame_switch,
   input  wire beat_t       camera_data,
   input  wire logic        p0_wr_full,
   input  wire logic        p0_cmd_full,
   output logic             p0_wr_en,
   output logic             p0_cmd_en,
   output beat_t            p0_wr_data,
   output byte_addr_t       p0_cmd_byte_addr
);

   write_state_t state;
   logic         hold;        // reset or memory not calibrated
   logic         take_beat;

   assign hold      = rst || !calib_done;
   assign take_beat = (state == write_idle) && wr_req && !wr_addr_load;

   // beat is held until the data FIFO accepts it
   always_ff @(posedge c3_clk0) begin
      if (take_beat) begin
         p0_wr_data <= camera_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // data write then single-beat write command
   ////////////////////////////////////////////////////////////

   always_ff @(posedge c3_clk0) begin
      if (hold) begin
         state            <= write_idle;
         p0_wr_en         <= 1'b0;
         p0_cmd_en        <= 1'b0;
         p0_cmd_byte_addr <= '0;
      end else if (wr_addr_load) begin
         // frame restart wins, sequence stays where it is
         p0_wr_en         <= 1'b0;
         p0_cmd_en        <= 1'b0;
         p0_cmd_byte_addr <= byte_addr_t'(frame_switch) * frame_stride;
      end else begin
         case (state)
            write_idle: begin
               if (wr_req) begin
                  state <= write_fifo;
               end
            end
            write_fifo: begin
               if (!p0_wr_full) begin   // room for the beat
                  p0_wr_en <= 1'b1;
                  state    <= write_data_done;
               end
            end
            write_data_done: begin
               p0_wr_en <= 1'b0;
               state    <= write_cmd_start;
            end
            write_cmd_start: begin
               state <= write_cmd;       // lets the beat land before the command
            end
            write_cmd: begin
               if (!p0_cmd_full) begin
                  p0_cmd_en <= 1'b1;
                  state     <= write_done;
               end
            end
            write_done: begin
               p0_cmd_en        <= 1'b0;
               p0_cmd_byte_addr <= p0_cmd_byte_addr + BEAT_BYTES;  // next beat slot
               state            <= write_idle;
            end
            default: begin
               p0_wr_en  <= 1'b0;
               p0_cmd_en <= 1'b0;
               state     <= write_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/strobe_sync.sv */
`default_nettype none

module strobe_sync (
   input  wire logic c3_clk0,
   input  wire logic rst,
   input  wire logic calib_done,
   input  wire logic wren,          // camera beat ready, rising edge
   input  wire logic rden,          // display read enable, toggles
   input  wire logic rd_cmd,        // burst read request, rising edge
   input  wire logic addr_wr_set,   // toggles on each write frame start
   input  wire logic addr_rd_set,   // toggles on each read frame start
   output logic      wr_req,
   output logic      rd_req,
   output logic      rd_cmd_req,
   output logic      wr_addr_load,
   output logic      rd_addr_load
);

   localparam int n_strobes = 5;

   // bit order: wren, rden, rd_cmd, addr_wr_set, addr_rd_set
   // set bits fire on both edges, the rest on the rising edge only
   localparam logic [n_strobes-1:0] any_edge = 5'b11010;

   logic [n_strobes-1:0] strobe_in;
   logic [n_strobes-1:0] sync_a;   // first stage, may settle late
   logic [n_strobes-1:0] sync_b;   // settled level, one cycle older
   logic [n_strobes-1:0] pulse;    // registered edge detect

   assign strobe_in = {addr_rd_set, addr_wr_set, rd_cmd, rden, wren};

   ////////////////////////////////////////////////////////////
   // two-flop sync plus edge register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge c3_clk0) begin
      if (rst || !calib_done) begin
         sync_a <= '0;
         sync_b <= '0;
         pulse  <= '0;
      end else begin
         sync_a <= strobe_in;
         sync_b <= sync_a;
         // a change, kept only if it is rising or the strobe toggles
         pulse  <= (sync_a ^ sync_b) & (any_edge | sync_a);
      end
   end

   assign wr_req       = pulse[0];
   assign rd_req       = pulse[1];
   assign rd_cmd_req   = pulse[2];
   assign wr_addr_load = pulse[3];
   assign rd_addr_load = pulse[4];

endmodule

`default_nettype wire

/* hw/ddr_rw_pkg.sv */
`default_nettype none

package ddr_rw_pkg;

   ////////////////////////////////////////////////////////////
   // widths seen on the controller user port
   ////////////////////////////////////////////////////////////

   typedef logic [29:0] byte_addr_t;    // command byte address
   typedef logic [63:0] beat_t;         // one 64-bit data beat
   typedef logic [5:0]  burst_len_t;    // beats minus one
   typedef logic [2:0]  cmd_instr_t;
   typedef logic [1:0]  frame_slot_t;   // one of four frame buffers

   ////////////////////////////////////////////////////////////
   // frame map and command codes
   ////////////////////////////////////////////////////////////

   localparam byte_addr_t  FRAME_STRIDE     = 30'd10_000_000;  // bytes per slot
   localparam byte_addr_t  BEAT_BYTES       = 30'd8;
   localparam int          READ_BURST_BEATS = 40;              // one display line chunk
   localparam cmd_instr_t  CMD_WRITE        = 3'b010;
   localparam cmd_instr_t  CMD_READ         = 3'b001;
   localparam frame_slot_t READ_SLOT_OFFSET = 2'd2;            // reader trails writer

   // port 0 write sequence, one camera beat per pass
   typedef enum logic [2:0] {
      write_idle      = 3'd0,
      write_fifo      = 3'd1,
      write_data_done = 3'd2,
      write_cmd_start = 3'd3,
      write_cmd       = 3'd4,
      write_done      = 3'd5
   } write_state_t;

   // port 1 burst read command sequence
   typedef enum logic [1:0] {
      read_idle      = 2'd0,
      read_cmd_start = 2'd1,
      read_cmd       = 2'd2,
      read_done      = 2'd3
   } read_state_t;

endpackage

`default_nettype wire
